// ==== tb.f ====
+incdir+rtl
+incdir+test
rtl/mips_pkg.sv
rtl/pipe_control.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/writeback_unit.sv
rtl/mips_pipeline.sv
test/tb_mips.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mips -f tb.f

out=$(./obj_dir/Vtb_mips)
echo "$out"

if grep -qx "Test completed successfully" <<< "$out"; then
    exit 0
fi
exit 1

// ==== test/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic word_t asm_r(input funct_t fn, input reg_idx_t rd, input reg_idx_t rs,
                                input reg_idx_t rt);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

// rt is the destination for addi/lw, the data for sw
function automatic word_t asm_i(input opcode_t op, input reg_idx_t rt, input reg_idx_t rs,
                                input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic emit(input word_t w);
    prog[prog_len] = w;
    prog_len++;
endtask

// every program first builds the data base in r28, no lui in the core
task automatic start_prog;
    int i;
    for (i = 0; i < 64; i++)
        prog[i] = `MIPS_NOP;                           // rest of rom is nops
    prog_len = 0;
    emit(asm_i(`OP_ADDI, 5'd28, 5'd0, 16'h1001));
    for (i = 0; i < 16; i++)
        emit(asm_r(`FN_ADD, 5'd28, 5'd28, 5'd28));     // doubling, back to back forward
    emit(asm_i(`OP_ADDI, 5'd28, 5'd28, 16'h8000));     // 0x1001_0000 - 0x8000
endtask

task automatic alu_chain_prog(input logic [15:0] imm1, input logic [15:0] imm2);
    start_prog;
    emit(asm_i(`OP_ADDI, 5'd1, 5'd0, imm1));
    emit(asm_i(`OP_ADDI, 5'd2, 5'd0, imm2));
    emit(asm_r(`FN_ADD, 5'd3, 5'd1, 5'd2));            // rs via MEM/WB, rt via EX/MEM
    emit(asm_r(`FN_SUB, 5'd4, 5'd3, 5'd1));            // r1 through write-through read
    emit(asm_r(`FN_AND, 5'd5, 5'd4, 5'd3));
    emit(asm_r(`FN_OR, 5'd6, 5'd5, 5'd2));
    emit(asm_r(`FN_SLT, 5'd7, 5'd6, 5'd1));
    emit(asm_i(`OP_SW, 5'd7, 5'd28, 16'd0));           // store data from EX/MEM
    emit(asm_i(`OP_SW, 5'd6, 5'd28, 16'd4));
    emit(asm_i(`OP_SW, 5'd5, 5'd28, 16'd8));
    emit(asm_i(`OP_SW, 5'd4, 5'd28, 16'd12));
    emit(asm_i(`OP_SW, 5'd3, 5'd28, 16'd16));
endtask

task automatic load_use_prog(input logic [15:0] addend);
    start_prog;
    emit(asm_i(`OP_ADDI, 5'd9, 5'd0, addend));
    emit(asm_i(`OP_LW, 5'd8, 5'd28, 16'd32));
    emit(asm_r(`FN_ADD, 5'd10, 5'd8, 5'd9));           // uses the load, one bubble
    emit(asm_i(`OP_SW, 5'd10, 5'd28, 16'd36));
    emit(asm_i(`OP_SW, 5'd8, 5'd28, 16'd40));
endtask

task automatic branch_prog;
    start_prog;
    emit(asm_i(`OP_ADDI, 5'd1, 5'd0, 16'd5));
    emit(asm_i(`OP_ADDI, 5'd2, 5'd0, 16'd5));
    emit(asm_i(`OP_ADDI, 5'd3, 5'd0, 16'd7));
    emit(asm_i(`OP_BEQ, 5'd3, 5'd1, 16'd2));           // 5 vs 7, falls through
    emit(asm_i(`OP_SW, 5'd1, 5'd28, 16'd0));
    emit(asm_i(`OP_BEQ, 5'd2, 5'd1, 16'd2));           // 5 vs 5, taken
    emit(asm_i(`OP_SW, 5'd2, 5'd28, 16'd4));           // delay slot
    emit(asm_i(`OP_SW, 5'd3, 5'd28, 16'd8));           // skipped
    emit(asm_i(`OP_SW, 5'd3, 5'd28, 16'd12));          // target
endtask

task automatic hazard_prog;
    start_prog;
    emit(asm_i(`OP_ADDI, 5'd4, 5'd0, 16'd9));
    emit(asm_i(`OP_ADDI, 5'd5, 5'd0, 16'd9));
    emit(asm_i(`OP_BEQ, 5'd5, 5'd4, 16'd2));           // alu producer in EX, taken
    emit(asm_i(`OP_SW, 5'd4, 5'd28, 16'd0));           // slot
    emit(asm_i(`OP_SW, 5'd4, 5'd28, 16'd4));           // skipped
    emit(asm_i(`OP_LW, 5'd6, 5'd28, 16'd64));
    emit(asm_i(`OP_LW, 5'd7, 5'd28, 16'd64));
    emit(asm_i(`OP_BEQ, 5'd7, 5'd6, 16'd2));           // load in EX, same word, taken
    emit(asm_i(`OP_SW, 5'd7, 5'd28, 16'd8));           // slot
    emit(asm_i(`OP_SW, 5'd7, 5'd28, 16'd12));          // skipped
    emit(asm_i(`OP_LW, 5'd8, 5'd28, 16'd68));
    emit(asm_i(`OP_ADDI, 5'd9, 5'd0, 16'd1));
    emit(asm_i(`OP_BEQ, 5'd4, 5'd8, 16'd2));           // load in MEM, not taken
    emit(asm_i(`OP_SW, 5'd8, 5'd28, 16'd16));          // slot
    emit(asm_i(`OP_SW, 5'd9, 5'd28, 16'd20));          // fall through
endtask

`endif

// ==== test/tb_mips.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module tb_mips;
    import mips_pkg::*;

    logic   clk;
    logic   rstn;
    word_t  imem_addr;
    word_t  imem_instr;
    word_t  dmem_addr;
    word_t  dmem_wdata;
    word_t  dmem_rdata;
    logic   dmem_we;
    logic   dmem_re;

    word_t  rom [64];                                  // instruction rom
    word_t  ram [256];                                 // data ram
    word_t  prog [64];                                 // program staged for the next reset
    int     prog_len;
    word_t  rom_off;
    word_t  ram_off;
    word_t  st_addr [$];                               // store log
    word_t  st_data [$];
    word_t  ld_addr [$];                               // load log
    integer seed;
    int     errors;
    int     checks;

    `include "tb_programs.svh"

    mips_pipeline u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .imem_addr  (imem_addr),
        .imem_instr (imem_instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                        // 40 ns period
    end

    // both memories answer in the same cycle
    assign rom_off    = imem_addr - `TEXT_START;
    assign imem_instr = (rom_off < 32'd256) ? rom[rom_off[7:2]] : `MIPS_NOP;
    assign ram_off    = dmem_addr - `DATA_START;
    assign dmem_rdata = ram[ram_off[9:2]];             // aliases outside the 1 KiB window

    function automatic word_t ram_fill(input word_t addr);
        return addr ^ 32'h5a5a_c3c3;                   // per-address pattern
    endfunction

    function automatic word_t sext16(input logic [15:0] h);
        return {{16{h[15]}}, h};
    endfunction

    // reset refills the ram and empties the logs
    always @(posedge clk) begin
        if (rstn === 1'b1) begin
            for (int i = 0; i < 256; i++)
                ram[i] <= ram_fill(`DATA_START + (word_t'(i) << 2));
            st_addr.delete();
            st_data.delete();
            ld_addr.delete();
        end else begin
            if (dmem_we === 1'b1) begin
                ram[ram_off[9:2]] <= dmem_wdata;
                st_addr.push_back(dmem_addr);
                st_data.push_back(dmem_wdata);
            end
            if (dmem_re === 1'b1)
                ld_addr.push_back(dmem_addr);          // one entry per load in MEM
        end
    end

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // 16 reset edges with the staged program copied in while the core is held
    task automatic reset_and_load;
        int i;
        @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);                                // first edge seen in reset
        for (i = 0; i < 64; i++)
            rom[i] = prog[i];
        for (i = 1; i <= 16; i++) begin
            @(negedge clk);
            check_eq("imem_addr", imem_addr, `MIPS_RESET_PC);
            check_eq("dmem_we", {31'b0, dmem_we}, 32'd0);
            check_eq("dmem_re", {31'b0, dmem_re}, 32'd0);
            @(posedge clk);
            if (i == 15)
                rstn <= 1'b0;                          // last check falls one cycle after
        end
    endtask

    task automatic wait_stores(input int n);
        int cycles;
        cycles = 0;
        while (st_addr.size() < n && cycles < 300) begin
            @(negedge clk);
            cycles++;
        end
        if (st_addr.size() < n) begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d stores seen",
                     cycles, st_addr.size(), n);
        end
        repeat (12)
            @(negedge clk);                            // drain so a late store shows up
        check_eq("store_count", word_t'(st_addr.size()), word_t'(n));
    endtask

    task automatic expect_store(input int k, input word_t addr, input word_t data);
        if (k >= st_addr.size()) begin
            errors++;
            $display("store number %0d never happened", k);
        end else begin
            check_eq("dmem_addr", st_addr[k], addr);
            check_eq("dmem_wdata", st_data[k], data);
        end
    endtask

    task automatic expect_load(input int k, input word_t addr);
        if (k >= ld_addr.size()) begin
            errors++;
            $display("load number %0d never happened", k);
        end else begin
            check_eq("dmem_addr", ld_addr[k], addr);
        end
    endtask

    task automatic alu_chain_test;
        word_t r1;
        word_t r2;
        word_t v1;
        word_t v2;
        word_t e3;
        word_t e4;
        word_t e5;
        word_t e6;
        word_t e7;
        int    n;
        for (n = 0; n < 3; n++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            v1 = sext16(r1[15:0]);
            v2 = sext16(r2[15:0]);
            e3 = v1 + v2;
            e4 = e3 - v1;
            e5 = e4 & e3;
            e6 = e5 | v2;
            e7 = ($signed(e6) < $signed(v1)) ? 32'd1 : 32'd0;
            alu_chain_prog(r1[15:0], r2[15:0]);
            reset_and_load;
            wait_stores(5);
            check_eq("load_count", word_t'(ld_addr.size()), 32'd0);
            expect_store(0, `DATA_START, e7);
            expect_store(1, `DATA_START + 32'd4, e6);
            expect_store(2, `DATA_START + 32'd8, e5);
            expect_store(3, `DATA_START + 32'd12, e4);
            expect_store(4, `DATA_START + 32'd16, e3);
        end
    endtask

    task automatic load_use_test;
        word_t r;
        word_t loaded;
        r      = $random(seed);
        loaded = ram_fill(`DATA_START + 32'd32);
        load_use_prog(r[15:0]);
        reset_and_load;
        wait_stores(2);
        check_eq("load_count", word_t'(ld_addr.size()), 32'd1);
        expect_load(0, `DATA_START + 32'd32);
        expect_store(0, `DATA_START + 32'd36, loaded + sext16(r[15:0]));
        expect_store(1, `DATA_START + 32'd40, loaded);
    endtask

    // not-taken slot then taken slot then target without the skipped sw
    task automatic branch_slot_test;
        branch_prog;
        reset_and_load;
        wait_stores(3);
        check_eq("load_count", word_t'(ld_addr.size()), 32'd0);
        expect_store(0, `DATA_START, 32'd5);
        expect_store(1, `DATA_START + 32'd4, 32'd5);
        expect_store(2, `DATA_START + 32'd12, 32'd7);
    endtask

    task automatic branch_hazard_test;
        word_t w64;
        word_t w68;
        w64 = ram_fill(`DATA_START + 32'd64);
        w68 = ram_fill(`DATA_START + 32'd68);          // never 9 so the third beq falls through
        hazard_prog;
        reset_and_load;
        wait_stores(4);
        check_eq("load_count", word_t'(ld_addr.size()), 32'd3);
        expect_load(0, `DATA_START + 32'd64);
        expect_load(1, `DATA_START + 32'd64);
        expect_load(2, `DATA_START + 32'd68);
        expect_store(0, `DATA_START, 32'd9);
        expect_store(1, `DATA_START + 32'd8, w64);
        expect_store(2, `DATA_START + 32'd16, w68);
        expect_store(3, `DATA_START + 32'd20, 32'd1);
    endtask

    initial begin
        seed     = 32'hecf4_870b;
        rstn     = 1'b1;                               // held in reset from time zero
        errors   = 0;
        checks   = 0;
        prog_len = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i]  = `MIPS_NOP;
            prog[i] = `MIPS_NOP;
        end
        alu_chain_test;
        load_use_test;
        branch_slot_test;
        branch_hazard_test;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== rtl/mips_pipeline.sv ====
`timescale 1ns/1ns

module mips_pipeline (
    input  logic            clk,
    input  logic            rstn,
    output mips_pkg::word_t imem_addr,
    input  mips_pkg::word_t imem_instr,
    output mips_pkg::word_t dmem_addr,
    output mips_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    output logic            dmem_re,
    input  mips_pkg::word_t dmem_rdata
);
    import mips_pkg::*;

    word_t    ifid_instr;
    word_t    ifid_pc4;
    word_t    branch_target;
    word_t    rs_data;
    word_t    rt_data;
    word_t    idex_a;
    word_t    idex_b;
    word_t    idex_imm;
    word_t    exmem_result;
    word_t    exmem_store;
    word_t    wb_data;
    reg_idx_t idex_rs;
    reg_idx_t idex_rt;
    reg_idx_t idex_dst;
    reg_idx_t exmem_dst;
    reg_idx_t memwb_dst;
    alu_sel_t alu_sel;
    alu_sel_t idex_alu_sel;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    fwd_sel_t br_fwd_a;
    fwd_sel_t br_fwd_b;
    logic     stall;
    logic     branch_taken;
    logic     reg_dst;
    logic     alu_src;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     reg_write;
    logic     branch;
    logic     idex_alu_src;
    logic     idex_mem_read;
    logic     idex_mem_write;
    logic     idex_mem_to_reg;
    logic     idex_reg_write;
    logic     exmem_reg_write;
    logic     exmem_mem_read;
    logic     exmem_mem_write;
    logic     exmem_mem_to_reg;
    logic     memwb_reg_write;

    // stage ports share the names of the nets above
    pipe_control u_control (.*);

    fetch_unit u_fetch (.*);

    reg_file u_regs (
        .clk     (clk),
        .rs      (ifid_instr[25:21]),
        .rt      (ifid_instr[20:16]),
        .wr_idx  (memwb_dst),
        .wr_en   (memwb_reg_write),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    decode_unit u_decode (.*);

    execute_unit u_execute (.*);

    writeback_unit u_writeback (.*);

    assign dmem_addr  = exmem_result;        // memory stage drives the ram
    assign dmem_wdata = exmem_store;
    assign dmem_we    = exmem_mem_write;
    assign dmem_re    = exmem_mem_read;

endmodule

// ==== rtl/writeback_unit.sv ====
`timescale 1ns/1ns

module writeback_unit (
    input  logic               clk,
    input  logic               rstn,
    input  mips_pkg::word_t    exmem_result,
    input  mips_pkg::word_t    dmem_rdata,
    input  mips_pkg::reg_idx_t exmem_dst,
    input  logic               exmem_reg_write,
    input  logic               exmem_mem_to_reg,
    output mips_pkg::word_t    wb_data,
    output mips_pkg::reg_idx_t memwb_dst,
    output logic               memwb_reg_write
);
    import mips_pkg::*;

    word_t memwb_result;
    word_t memwb_rdata;
    logic  memwb_mem_to_reg;

    always_ff @(posedge clk) begin
        if (rstn) begin
            memwb_reg_write  <= 1'b0;
            memwb_mem_to_reg <= 1'b0;
        end else begin
            memwb_reg_write  <= exmem_reg_write;
            memwb_mem_to_reg <= exmem_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        memwb_result <= exmem_result;
        memwb_rdata  <= dmem_rdata;           // ram answers combinationally
        memwb_dst    <= exmem_dst;
    end

    assign wb_data = memwb_mem_to_reg ? memwb_rdata : memwb_result;

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module execute_unit (
    input  logic               clk,
    input  logic               rstn,
    input  mips_pkg::word_t    idex_a,
    input  mips_pkg::word_t    idex_b,
    input  mips_pkg::word_t    idex_imm,
    input  mips_pkg::reg_idx_t idex_dst,
    input  logic               idex_alu_src,
    input  logic               idex_mem_read,
    input  logic               idex_mem_write,
    input  logic               idex_mem_to_reg,
    input  logic               idex_reg_write,
    input  mips_pkg::alu_sel_t idex_alu_sel,
    input  mips_pkg::fwd_sel_t fwd_a,
    input  mips_pkg::fwd_sel_t fwd_b,
    input  mips_pkg::word_t    wb_data,
    output mips_pkg::word_t    exmem_result,
    output mips_pkg::word_t    exmem_store,
    output mips_pkg::reg_idx_t exmem_dst,
    output logic               exmem_reg_write,
    output logic               exmem_mem_read,
    output logic               exmem_mem_write,
    output logic               exmem_mem_to_reg
);
    import mips_pkg::*;

    word_t op_a;
    word_t rt_val;                           // forwarded rt, also store data
    word_t op_b;
    word_t alu_out;

    assign op_a   = fwd_pick(fwd_a, idex_a, exmem_result, wb_data);
    assign rt_val = fwd_pick(fwd_b, idex_b, exmem_result, wb_data);
    assign op_b   = idex_alu_src ? idex_imm : rt_val;

    always_comb begin
        case (idex_alu_sel)
            `ALU_AND: alu_out = op_a & op_b;
            `ALU_OR:  alu_out = op_a | op_b;
            `ALU_SUB: alu_out = op_a - op_b;
            `ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            default:  alu_out = op_a + op_b;  // add, addi, lw/sw address
        endcase
    end

    always_ff @(posedge clk) begin
        if (rstn) begin
            exmem_reg_write  <= 1'b0;
            exmem_mem_read   <= 1'b0;
            exmem_mem_write  <= 1'b0;
            exmem_mem_to_reg <= 1'b0;
        end else begin
            exmem_reg_write  <= idex_reg_write;
            exmem_mem_read   <= idex_mem_read;
            exmem_mem_write  <= idex_mem_write;
            exmem_mem_to_reg <= idex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        exmem_result <= alu_out;              // also the dmem address
        exmem_store  <= rt_val;
        exmem_dst    <= idex_dst;
    end

    // load-use stall keeps a consumer out of EX while the load is in MEM
    a_no_load_addr_fwd: assert property (@(posedge clk) disable iff (rstn)
        exmem_mem_read |-> (fwd_a != `FWD_EXMEM));

endmodule

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module decode_unit (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  mips_pkg::word_t    ifid_instr,
    input  mips_pkg::word_t    ifid_pc4,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    input  mips_pkg::word_t    exmem_result,
    input  mips_pkg::word_t    wb_data,
    input  mips_pkg::fwd_sel_t br_fwd_a,
    input  mips_pkg::fwd_sel_t br_fwd_b,
    input  logic               reg_dst,
    input  logic               alu_src,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               mem_to_reg,
    input  logic               reg_write,
    input  logic               branch,
    input  mips_pkg::alu_sel_t alu_sel,
    output logic               branch_taken,
    output mips_pkg::word_t    branch_target,
    output mips_pkg::word_t    idex_a,
    output mips_pkg::word_t    idex_b,
    output mips_pkg::word_t    idex_imm,
    output mips_pkg::reg_idx_t idex_rs,
    output mips_pkg::reg_idx_t idex_rt,
    output mips_pkg::reg_idx_t idex_dst,
    output logic               idex_alu_src,
    output logic               idex_mem_read,
    output logic               idex_mem_write,
    output logic               idex_mem_to_reg,
    output logic               idex_reg_write,
    output mips_pkg::alu_sel_t idex_alu_sel
);
    import mips_pkg::*;

    word_t imm;
    word_t cmp_a;
    word_t cmp_b;

    assign imm           = {{16{ifid_instr[15]}}, ifid_instr[15:0]};
    assign branch_target = ifid_pc4 + {imm[29:0], 2'b00}; // word offset
    assign cmp_a         = fwd_pick(br_fwd_a, rs_data, exmem_result, wb_data);
    assign cmp_b         = fwd_pick(br_fwd_b, rt_data, exmem_result, wb_data);
    assign branch_taken  = branch && (cmp_a == cmp_b);

    always_ff @(posedge clk) begin
        if (rstn || stall) begin             // bubble on stall
            idex_alu_src    <= 1'b0;
            idex_mem_read   <= 1'b0;
            idex_mem_write  <= 1'b0;
            idex_mem_to_reg <= 1'b0;
            idex_reg_write  <= 1'b0;
            idex_alu_sel    <= '0;
            idex_rs         <= '0;           // bubble matches no producer
            idex_rt         <= '0;
            idex_dst        <= '0;
        end else begin
            idex_alu_src    <= alu_src;
            idex_mem_read   <= mem_read;
            idex_mem_write  <= mem_write;
            idex_mem_to_reg <= mem_to_reg;
            idex_reg_write  <= reg_write;
            idex_alu_sel    <= alu_sel;
            idex_rs         <= ifid_instr[25:21];
            idex_rt         <= ifid_instr[20:16];
            idex_dst        <= reg_dst ? ifid_instr[15:11] : ifid_instr[20:16];
        end
    end

    always_ff @(posedge clk) begin
        idex_a   <= rs_data;
        idex_b   <= rt_data;                 // store data or alu b
        idex_imm <= imm;
    end

    // a held branch must not redirect fetch
    a_no_take_on_stall: assert property (@(posedge clk) disable iff (rstn)
        !(branch_taken && stall));

    // only a real dependency stalls, never the reset bubble
    a_nop_never_stalls: assert property (@(posedge clk) disable iff (rstn)
        (ifid_instr == `MIPS_NOP) |-> !stall);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  mips_pkg::reg_idx_t rs,
    input  mips_pkg::reg_idx_t rt,
    input  mips_pkg::reg_idx_t wr_idx,
    input  logic               wr_en,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data
);
    import mips_pkg::*;

    word_t regs [32];                        // entry 0 never written

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0)
            regs[wr_idx] <= wr_data;
    end

    // write-through so decode sees the value retiring this cycle
    assign rs_data = (rs == '0) ? '0 :
                     (wr_en && wr_idx == rs) ? wr_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (wr_en && wr_idx == rt) ? wr_data : regs[rt];

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module fetch_unit (
    input  logic            clk,
    input  logic            rstn,
    input  logic            stall,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    input  mips_pkg::word_t imem_instr,
    output mips_pkg::word_t imem_addr,
    output mips_pkg::word_t ifid_instr,
    output mips_pkg::word_t ifid_pc4
);
    import mips_pkg::*;

    word_t pc;
    word_t pc4;

    assign imem_addr = pc;                   // rom answers this cycle
    assign pc4       = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rstn) begin
            pc         <= `MIPS_RESET_PC;
            ifid_instr <= `MIPS_NOP;         // decode sees a bubble
        end else if (!stall) begin
            pc         <= branch_taken ? branch_target : pc4;
            ifid_instr <= imem_instr;        // delay slot enters here too
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            ifid_pc4 <= pc4;                 // for the branch target
    end

endmodule

// ==== rtl/pipe_control.sv ====
`timescale 1ns/1ns
`include "mips_consts.svh"

module pipe_control (
    input  mips_pkg::word_t    ifid_instr,
    input  mips_pkg::reg_idx_t idex_rs,
    input  mips_pkg::reg_idx_t idex_rt,
    input  mips_pkg::reg_idx_t idex_dst,
    input  logic               idex_reg_write,
    input  logic               idex_mem_read,
    input  mips_pkg::reg_idx_t exmem_dst,
    input  logic               exmem_reg_write,
    input  logic               exmem_mem_read,
    input  mips_pkg::reg_idx_t memwb_dst,
    input  logic               memwb_reg_write,
    output logic               reg_dst,
    output logic               alu_src,
    output logic               mem_read,
    output logic               mem_write,
    output logic               mem_to_reg,
    output logic               reg_write,
    output logic               branch,
    output mips_pkg::alu_sel_t alu_sel,
    output mips_pkg::fwd_sel_t fwd_a,
    output mips_pkg::fwd_sel_t fwd_b,
    output mips_pkg::fwd_sel_t br_fwd_a,
    output mips_pkg::fwd_sel_t br_fwd_b,
    output logic               stall
);
    import mips_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t ifid_rs;
    reg_idx_t ifid_rt;
    logic     is_beq;           // beq sitting in decode
    logic     uses_rs;          // decode instr reads rs
    logic     uses_rt;          // decode instr reads rt
    logic     dep_ex;           // decode reads the ID/EX destination
    logic     dep_mem;          // decode reads the EX/MEM destination

    assign opcode  = ifid_instr[31:26];
    assign funct   = ifid_instr[5:0];
    assign ifid_rs = ifid_instr[25:21];
    assign ifid_rt = ifid_instr[20:16];

    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        is_beq     = 1'b0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        alu_sel    = `ALU_ADD;              // address and addi default
        case (opcode)
            `OP_RTYPE: begin
                reg_dst   = 1'b1;            // rd
                reg_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                case (funct)
                    `FN_SUB: alu_sel = `ALU_SUB;
                    `FN_AND: alu_sel = `ALU_AND;
                    `FN_OR:  alu_sel = `ALU_OR;
                    `FN_SLT: alu_sel = `ALU_SLT;
                    default: alu_sel = `ALU_ADD; // add, also the nop
                endcase
            end
            `OP_LW: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                uses_rs    = 1'b1;           // base only
            end
            `OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;            // store data
            end
            `OP_BEQ: begin
                is_beq  = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                alu_sel = `ALU_SUB;
            end
            `OP_ADDI: begin
                alu_src   = 1'b1;            // immediate into alu b
                reg_write = 1'b1;
                uses_rs   = 1'b1;
            end
            default: ;                       // unknown opcode, no effect
        endcase
    end

    assign dep_ex  = (idex_dst != '0) && ((uses_rs && idex_dst == ifid_rs) ||
                                          (uses_rt && idex_dst == ifid_rt));
    assign dep_mem = (exmem_dst != '0) && ((uses_rs && exmem_dst == ifid_rs) ||
                                           (uses_rt && exmem_dst == ifid_rt));

    // load-use, branch on alu result in EX, branch on load in EX or MEM
    assign stall = (idex_mem_read && dep_ex) ||
                   (is_beq && idex_reg_write && dep_ex) ||
                   (is_beq && exmem_mem_read && dep_mem);

    assign branch = is_beq && !stall;        // compare only once operands are ready

    // newest producer wins, r0 never forwarded
    function automatic fwd_sel_t pick_src(reg_idx_t r);
        if (r == '0)
            return `FWD_REG;
        if (exmem_reg_write && exmem_dst == r)
            return `FWD_EXMEM;
        if (memwb_reg_write && memwb_dst == r)
            return `FWD_WB;
        return `FWD_REG;
    endfunction

    always_comb begin
        fwd_a    = pick_src(idex_rs);        // alu operands
        fwd_b    = pick_src(idex_rt);
        br_fwd_a = pick_src(ifid_rs);        // branch comparator
        br_fwd_b = pick_src(ifid_rt);
    end

endmodule

// ==== rtl/mips_pkg.sv ====
`include "mips_consts.svh"

package mips_pkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0]  reg_idx_t; // register number
    typedef logic [5:0]  opcode_t;  // instr[31:26]
    typedef logic [5:0]  funct_t;   // instr[5:0]
    typedef logic [3:0]  alu_sel_t; // alu operation
    typedef logic [1:0]  fwd_sel_t; // operand source

    // operand mux shared by the branch comparator and the alu inputs
    function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val,
                                       word_t exmem_val, word_t wb_val);
        case (sel)
            `FWD_EXMEM: return exmem_val; // producer in memory stage
            `FWD_WB:    return wb_val;    // producer in write-back
            default:    return reg_val;
        endcase
    endfunction

endpackage

// ==== rtl/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_RESET_PC 32'h0040_0000 // first fetch address
`define TEXT_START    32'h0040_0000 // instruction rom base
`define DATA_START    32'h1000_8000 // data ram base

`define OP_RTYPE 6'h00
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04
`define OP_ADDI  6'h08

`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`define ALU_AND 4'b0000
`define ALU_OR  4'b0001
`define ALU_ADD 4'b0010
`define ALU_SUB 4'b0110
`define ALU_SLT 4'b0111 // signed compare

`define FWD_REG   2'd0 // value read in decode
`define FWD_EXMEM 2'd1 // alu result one stage ahead
`define FWD_WB    2'd2 // write-back data

`define MIPS_NOP 32'h0000_0000 // sll r0, r0, 0

`endif
